// File: design/photon_plot_pkg.sv
`default_nettype none

package photon_plot_pkg;

    ////////////////////////////////////////
    // Vector types.
    ////////////////////////////////////////
    typedef logic [23:0] sdram_addr_t;   // Bank(2) + row(13) + column(9).
    typedef logic [15:0] sdram_data_t;   // One SDRAM word.
    typedef logic [15:0] pulse_count_t;  // One photon counter sample.
    typedef logic [9:0]  ring_slot_t;    // Ring index, 0 to 599.
    typedef logic [15:0] pixel_t;        // RGB565.
    typedef logic [8:0]  bar_pos_t;      // Column inside one bar row.

    ////////////////////////////////////////
    // SDRAM address map.
    ////////////////////////////////////////
    // GRAM occupies words 0 to 383999 (480 x 800).
    localparam sdram_addr_t RING_BASE  = 24'd384000;  // Ring slot 0.
    localparam int          RING_DEPTH = 600;         // Samples, also bar rows.

    // Plot geometry on the panel.
    localparam int GRAM_WIDTH    = 480;  // Pixels per GRAM row.
    localparam int PLOT_Y_OFFSET = 20;   // First bar row.
    localparam int PLOT_X_OFFSET = 10;   // First bar column.
    localparam int BAR_SPAN      = 470;  // Pixels written per row.
    localparam int BAR_SHIFT     = 1;    // Sample to bar length.

    // Colours.
    localparam pixel_t COLOR_BAR = 16'hF81F;  // Magenta-pink.
    localparam pixel_t COLOR_BG  = 16'h0000;  // Black.

    ////////////////////////////////////////
    // State encodings.
    ////////////////////////////////////////
    typedef enum logic [2:0] {
        rs_idle,        // Waiting for en to start a frame.
        rs_read,        // Raise ring read.
        rs_wait_read,   // Wait for rd_done.
        rs_pixel,       // Raise one pixel write.
        rs_wait_pixel,  // Wait for wr_done.
        rs_next_row     // Step slot, row and row address.
    } renderer_state_t;

    typedef enum logic [1:0] {
        own_idle,
        own_logger,
        own_renderer_write,
        own_renderer_read
    } mux_owner_t;

endpackage

`default_nettype wire

// File: design/sample_logger.sv
`timescale 1ns/100ps
`default_nettype none

module sample_logger (
    input  wire                           clk,
    input  wire                           rst_n,
    input  wire                           en,
    input  wire                           data_update,  // One-cycle strobe.
    input  wire photon_plot_pkg::pulse_count_t pulse_count,
    output logic                          log_wr_req,   // Level until done.
    output photon_plot_pkg::sdram_addr_t  log_wr_addr,
    output photon_plot_pkg::sdram_data_t  log_wr_data,
    input  wire                           log_wr_done,
    output photon_plot_pkg::ring_slot_t   head          // Next slot, oldest sample.
);

    photon_plot_pkg::pulse_count_t pending_data;  // Latest unwritten sample.
    logic                          pending;       // pending_data not yet issued.
    logic                          issue;         // Start a ring write this edge.
    photon_plot_pkg::ring_slot_t   next_head;

    assign issue = !log_wr_req && pending && en;

    // Wrap 599 back to 0.
    assign next_head = (head == photon_plot_pkg::ring_slot_t'(photon_plot_pkg::RING_DEPTH - 1))
                     ? '0 : head + 1'b1;

    // Ring slot address.
    assign log_wr_addr = photon_plot_pkg::RING_BASE + photon_plot_pkg::sdram_addr_t'(head);

    ////////////////////////////////////////
    // Sample capture.
    always_ff @(posedge clk) begin
        if (data_update) begin
            pending_data <= pulse_count;  // Newer strobe overwrites.
        end
        if (issue) begin
            log_wr_data <= pending_data;  // Frozen for the whole request.
        end
    end

    ////////////////////////////////////////
    // Request and head pointer.
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pending    <= 1'b0;
            log_wr_req <= 1'b0;
            head       <= '0;
        end else begin
            if (log_wr_req) begin
                if (log_wr_done) begin
                    log_wr_req <= 1'b0;  // Drop in the cycle after done.
                    head       <= next_head;
                end
            end else if (issue) begin
                log_wr_req <= 1'b1;
            end

            // A strobe on the issue edge keeps the flag set.
            if (data_update) begin
                pending <= 1'b1;
            end else if (issue) begin
                pending <= 1'b0;
            end
        end
    end

endmodule

`default_nettype wire

// File: design/bar_renderer.sv
`timescale 1ns/100ps
`default_nettype none

module bar_renderer (
    input  wire                          clk,
    input  wire                          rst_n,
    input  wire                          en,
    input  wire photon_plot_pkg::ring_slot_t  head,     // Oldest slot.
    output logic                         rd_req,
    output photon_plot_pkg::sdram_addr_t rd_addr,
    input  wire photon_plot_pkg::sdram_data_t rd_data,
    input  wire                          rd_done,
    output logic                         px_wr_req,
    output photon_plot_pkg::sdram_addr_t px_wr_addr,
    output photon_plot_pkg::pixel_t      px_wr_data,
    input  wire                          px_wr_done,
    output logic                         frame_done     // One pulse per frame.
);

    photon_plot_pkg::renderer_state_t state;
    photon_plot_pkg::ring_slot_t      rd_slot;    // Slot of the current row.
    photon_plot_pkg::ring_slot_t      row_cnt;    // Row 0 to 599.
    photon_plot_pkg::bar_pos_t        px_cnt;     // Pixel 0 to 469.
    photon_plot_pkg::bar_pos_t        bar_len;    // Last pink column.
    photon_plot_pkg::sdram_addr_t     row_addr;   // GRAM address of pixel 0.
    photon_plot_pkg::sdram_data_t     scaled;     // Sample after the shift.
    photon_plot_pkg::bar_pos_t        clip_len;
    logic                             last_px;
    logic                             last_row;
    logic                             start_frame;

    ////////////////////////////////////////
    // Combinational helpers.
    assign last_px  = (px_cnt == photon_plot_pkg::bar_pos_t'(photon_plot_pkg::BAR_SPAN - 1));
    assign last_row = (row_cnt == photon_plot_pkg::ring_slot_t'(photon_plot_pkg::RING_DEPTH - 1));

    // From idle, or straight off the last pixel of a frame.
    assign start_frame = en && ((state == photon_plot_pkg::rs_idle) ||
                                (state == photon_plot_pkg::rs_wait_pixel &&
                                 px_wr_done && last_px && last_row));

    // Sample to bar length, clipped to the span.
    assign scaled   = rd_data >> photon_plot_pkg::BAR_SHIFT;
    assign clip_len = (scaled > photon_plot_pkg::sdram_data_t'(photon_plot_pkg::BAR_SPAN - 1))
                    ? photon_plot_pkg::bar_pos_t'(photon_plot_pkg::BAR_SPAN - 1)
                    : photon_plot_pkg::bar_pos_t'(scaled);

    assign rd_addr    = photon_plot_pkg::RING_BASE + photon_plot_pkg::sdram_addr_t'(rd_slot);
    assign px_wr_addr = row_addr + photon_plot_pkg::sdram_addr_t'(px_cnt);

    ////////////////////////////////////////
    // Row datapath.
    always_ff @(posedge clk) begin
        if (start_frame) begin
            // Top bar row, first bar column.
            row_addr <= photon_plot_pkg::sdram_addr_t'(photon_plot_pkg::PLOT_Y_OFFSET *
                        photon_plot_pkg::GRAM_WIDTH + photon_plot_pkg::PLOT_X_OFFSET);
        end else if (state == photon_plot_pkg::rs_next_row) begin
            row_addr <= row_addr + photon_plot_pkg::sdram_addr_t'(photon_plot_pkg::GRAM_WIDTH);
        end

        if (state == photon_plot_pkg::rs_wait_read && rd_done) begin
            bar_len <= clip_len;
        end

        // Pink up to the bar length, black after it.
        if (state == photon_plot_pkg::rs_pixel && en) begin
            px_wr_data <= (px_cnt <= bar_len) ? photon_plot_pkg::COLOR_BAR
                                              : photon_plot_pkg::COLOR_BG;
        end
    end

    ////////////////////////////////////////
    // Frame FSM.
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state      <= photon_plot_pkg::rs_idle;
            rd_slot    <= '0;
            row_cnt    <= '0;
            px_cnt     <= '0;
            rd_req     <= 1'b0;
            px_wr_req  <= 1'b0;
            frame_done <= 1'b0;
        end else begin
            frame_done <= start_frame;
            if (start_frame) begin
                rd_slot   <= head;  // Oldest sample first.
                row_cnt   <= '0;
                px_wr_req <= 1'b0;
                state     <= photon_plot_pkg::rs_read;
            end else begin
                case (state)
                    photon_plot_pkg::rs_read: begin
                        if (en) begin
                            rd_req <= 1'b1;
                            state  <= photon_plot_pkg::rs_wait_read;
                        end
                    end
                    photon_plot_pkg::rs_wait_read: begin
                        if (rd_done) begin
                            rd_req <= 1'b0;
                            px_cnt <= '0;
                            state  <= photon_plot_pkg::rs_pixel;
                        end
                    end
                    photon_plot_pkg::rs_pixel: begin
                        if (en) begin
                            px_wr_req <= 1'b1;
                            state     <= photon_plot_pkg::rs_wait_pixel;
                        end
                    end
                    photon_plot_pkg::rs_wait_pixel: begin
                        if (px_wr_done) begin
                            px_wr_req <= 1'b0;
                            if (!last_px) begin
                                px_cnt <= px_cnt + 1'b1;
                                state  <= photon_plot_pkg::rs_pixel;
                            end else if (!last_row) begin
                                state <= photon_plot_pkg::rs_next_row;
                            end else begin
                                state <= photon_plot_pkg::rs_idle;  // Frame end, en low.
                            end
                        end
                    end
                    photon_plot_pkg::rs_next_row: begin
                        row_cnt <= row_cnt + 1'b1;
                        rd_slot <= (rd_slot == photon_plot_pkg::ring_slot_t'(
                                    photon_plot_pkg::RING_DEPTH - 1)) ? '0 : rd_slot + 1'b1;
                        state   <= photon_plot_pkg::rs_read;
                    end
                    default: begin
                        state <= photon_plot_pkg::rs_idle;
                    end
                endcase
            end
        end
    end

endmodule

`default_nettype wire

// File: design/mem_port_mux.sv
`timescale 1ns/100ps
`default_nettype none

module mem_port_mux (
    input  wire                          clk,
    input  wire                          rst_n,
    // Logger ring writes.
    input  wire                          log_wr_req,
    input  wire photon_plot_pkg::sdram_addr_t log_wr_addr,
    input  wire photon_plot_pkg::sdram_data_t log_wr_data,
    output logic                         log_wr_done,
    // Renderer pixel writes.
    input  wire                          px_wr_req,
    input  wire photon_plot_pkg::sdram_addr_t px_wr_addr,
    input  wire photon_plot_pkg::sdram_data_t px_wr_data,
    output logic                         px_wr_done,
    // Renderer ring reads.
    input  wire                          px_rd_req,
    input  wire photon_plot_pkg::sdram_addr_t px_rd_addr,
    output logic                         px_rd_done,
    // SDRAM glue port.
    output logic                         rd_req,
    output photon_plot_pkg::sdram_addr_t rd_addr,
    input  wire                          rd_done,
    output logic                         wr_req,
    output photon_plot_pkg::sdram_addr_t wr_addr,
    output photon_plot_pkg::sdram_data_t wr_data,
    input  wire                          wr_done
);

    photon_plot_pkg::mux_owner_t owner;  // Holder of the outstanding operation.
    photon_plot_pkg::mux_owner_t grant;  // Owner for this cycle.
    logic                        owner_done;

    ////////////////////////////////////////
    // Fixed priority when free.
    always_comb begin
        grant = owner;
        if (owner == photon_plot_pkg::own_idle) begin
            if (log_wr_req) begin
                grant = photon_plot_pkg::own_logger;
            end else if (px_wr_req) begin
                grant = photon_plot_pkg::own_renderer_write;
            end else if (px_rd_req) begin
                grant = photon_plot_pkg::own_renderer_read;
            end
        end
    end

    // Same-cycle pass-through of the granted request.
    assign wr_req  = (grant == photon_plot_pkg::own_logger && log_wr_req) ||
                     (grant == photon_plot_pkg::own_renderer_write && px_wr_req);
    assign wr_addr = (grant == photon_plot_pkg::own_logger) ? log_wr_addr : px_wr_addr;
    assign wr_data = (grant == photon_plot_pkg::own_logger) ? log_wr_data : px_wr_data;
    assign rd_req  = (grant == photon_plot_pkg::own_renderer_read) && px_rd_req;
    assign rd_addr = px_rd_addr;

    // Done pulses go back to the owner only.
    assign log_wr_done = wr_done && (grant == photon_plot_pkg::own_logger);
    assign px_wr_done  = wr_done && (grant == photon_plot_pkg::own_renderer_write);
    assign px_rd_done  = rd_done && (grant == photon_plot_pkg::own_renderer_read);
    assign owner_done  = log_wr_done || px_wr_done || px_rd_done;

    ////////////////////////////////////////
    // Owner register.
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            owner <= photon_plot_pkg::own_idle;
        end else if (owner_done) begin
            owner <= photon_plot_pkg::own_idle;  // Free again after done.
        end else begin
            owner <= grant;
        end
    end

endmodule

`default_nettype wire

// File: design/photon_plot_top.sv
`timescale 1ns/100ps
`default_nettype none

module photon_plot_top (
    input  wire                          clk,
    input  wire                          rst_n,
    input  wire                          en,
    input  wire                          data_update,
    input  wire photon_plot_pkg::pulse_count_t pulse_count,
    output logic                         rd_req,
    output photon_plot_pkg::sdram_addr_t rd_addr,
    input  wire photon_plot_pkg::sdram_data_t rd_data,
    input  wire                          rd_done,
    output logic                         wr_req,
    output photon_plot_pkg::sdram_addr_t wr_addr,
    output photon_plot_pkg::sdram_data_t wr_data,
    input  wire                          wr_done,
    output logic                         frame_done
);

    ////////////////////////////////////////
    // Internal request paths.
    logic                         log_wr_req;
    photon_plot_pkg::sdram_addr_t log_wr_addr;
    photon_plot_pkg::sdram_data_t log_wr_data;
    logic                         log_wr_done;
    photon_plot_pkg::ring_slot_t  head;          // Logger to renderer.

    logic                         px_wr_req;
    photon_plot_pkg::sdram_addr_t px_wr_addr;
    photon_plot_pkg::pixel_t      px_wr_data;
    logic                         px_wr_done;
    logic                         px_rd_req;
    photon_plot_pkg::sdram_addr_t px_rd_addr;
    logic                         px_rd_done;

    // Ring writer.
    sample_logger sample_logger_i (
        .clk         (clk),
        .rst_n       (rst_n),
        .en          (en),
        .data_update (data_update),
        .pulse_count (pulse_count),
        .log_wr_req  (log_wr_req),
        .log_wr_addr (log_wr_addr),
        .log_wr_data (log_wr_data),
        .log_wr_done (log_wr_done),
        .head        (head)
    );

    // Ring reader and bar painter.
    bar_renderer bar_renderer_i (
        .clk        (clk),
        .rst_n      (rst_n),
        .en         (en),
        .head       (head),
        .rd_req     (px_rd_req),
        .rd_addr    (px_rd_addr),
        .rd_data    (rd_data),      // Read data needs no steering.
        .rd_done    (px_rd_done),
        .px_wr_req  (px_wr_req),
        .px_wr_addr (px_wr_addr),
        .px_wr_data (px_wr_data),
        .px_wr_done (px_wr_done),
        .frame_done (frame_done)
    );

    // One SDRAM operation at a time.
    mem_port_mux mem_port_mux_i (
        .clk         (clk),
        .rst_n       (rst_n),
        .log_wr_req  (log_wr_req),
        .log_wr_addr (log_wr_addr),
        .log_wr_data (log_wr_data),
        .log_wr_done (log_wr_done),
        .px_wr_req   (px_wr_req),
        .px_wr_addr  (px_wr_addr),
        .px_wr_data  (px_wr_data),
        .px_wr_done  (px_wr_done),
        .px_rd_req   (px_rd_req),
        .px_rd_addr  (px_rd_addr),
        .px_rd_done  (px_rd_done),
        .rd_req      (rd_req),
        .rd_addr     (rd_addr),
        .rd_done     (rd_done),
        .wr_req      (wr_req),
        .wr_addr     (wr_addr),
        .wr_data     (wr_data),
        .wr_done     (wr_done)
    );

endmodule

`default_nettype wire

// File: dv/tb_clock_gen.sv
`timescale 1ns/100ps
`default_nettype none

module tb_clock_gen (
    output logic clk,
    output logic rst_n
);

    localparam int HALF_PERIOD = 50;  // 100 ns clock.
    localparam int RESET_CYCLES = 16;

    initial begin
        clk = 1'b0;
        forever #HALF_PERIOD clk = ~clk;
    end

    // Release off the edge, like the other inputs.
    initial begin
        rst_n = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        #10;
        rst_n = 1'b1;
    end

endmodule

`default_nettype wire

// File: dv/plot_checker.sv
`timescale 1ns/100ps
`default_nettype none

module plot_checker (
    input  wire                                clk,
    input  wire                                rst_n,
    input  wire                                en,
    input  wire                                data_update,
    input  wire photon_plot_pkg::pulse_count_t pulse_count,
    input  wire                                rd_req,
    input  wire photon_plot_pkg::sdram_addr_t  rd_addr,
    input  wire photon_plot_pkg::sdram_data_t  rd_data,
    input  wire                                rd_done,
    input  wire                                wr_req,
    input  wire photon_plot_pkg::sdram_addr_t  wr_addr,
    input  wire photon_plot_pkg::sdram_data_t  wr_data,
    input  wire                                wr_done,
    input  wire                                frame_done,
    output int                                 err_count,
    output int                                 check_count
);

    localparam int RING_LO  = int'(photon_plot_pkg::RING_BASE);
    localparam int RING_HI  = RING_LO + photon_plot_pkg::RING_DEPTH;
    localparam int SPAN     = photon_plot_pkg::BAR_SPAN;
    localparam int SAMPLE_LIMIT = 200;  // Cycles a sample may wait for the ring.

    logic [15:0]  shadow [0:photon_plot_pkg::RING_DEPTH-1];  // Ring contents.
    logic [15:0]  strobes [$];  // Samples not yet written.
    int  wcount;          // Completed ring writes.
    int  wcount_snap;     // wcount before the last edge.
    int  frame_first;
    int  reads_in_frame;
    int  pix_idx;         // SPAN means no row open.
    int  row_start;
    int  bar_len;
    int  frames;
    int  post_rst;
    int  unwritten;       // Cycles the oldest pending sample has waited.
    logic en_d, rd_req_d, wr_req_d, rd_done_d, wr_done_d;
    photon_plot_pkg::sdram_addr_t rd_addr_d, wr_addr_d;
    photon_plot_pkg::sdram_data_t wr_data_d;

    initial begin
        err_count = 0;
        check_count = 0;
        wcount = 0;
        wcount_snap = 0;
        frame_first = 0;
        reads_in_frame = 0;
        pix_idx = SPAN;
        frames = 0;
        post_rst = 0;
        unwritten = 0;
        foreach (shadow[i]) shadow[i] = 16'h0000;
    end

    ////////////////////////////////////////
    // Reporting.
    ////////////////////////////////////////
    task automatic compare(input string name, input logic [31:0] got, input logic [31:0] exp);
        check_count++;
        if (got !== exp) begin
            err_count++;
            $display("ERR t=%0t %s got 0x%0h expected 0x%0h", $time, name, got, exp);
        end
    endtask

    task automatic fail(input string what);
        err_count++;
        $display("Error at %0t: %s", $time, what);
    endtask

    // Ring write data must match a pending sample; older ones were overwritten.
    task automatic consume_sample(input logic [15:0] data);
        int idx;
        idx = -1;
        for (int i = strobes.size() - 1; i >= 0 && idx < 0; i--) begin
            if (strobes[i] == data) idx = i;
        end
        check_count++;
        if (idx < 0) begin
            fail($sformatf("ring write of 0x%0h matches no pending sample", data));
        end else begin
            for (int i = 0; i <= idx; i++) void'(strobes.pop_front());
            unwritten = 0;
        end
    endtask

    ////////////////////////////////////////
    // Port watch, sampled on the rising edge.
    ////////////////////////////////////////
    always @(posedge clk) begin
        int slot;
        // Reset and first cycle after it.
        if (!rst_n || post_rst == 0) begin
            compare("rd_req", 32'(rd_req), 0);
            compare("wr_req", 32'(wr_req), 0);
            compare("frame_done", 32'(frame_done), 0);
        end
        post_rst = rst_n ? post_rst + 1 : 0;

        if (rst_n) begin
            if (rd_req && wr_req) fail("rd_req and wr_req high together");
            // Held stable until done.
            if (wr_req && wr_req_d && !wr_done_d) begin
                compare("wr_addr", 32'(wr_addr), 32'(wr_addr_d));
                compare("wr_data", 32'(wr_data), 32'(wr_data_d));
            end
            if (rd_req && rd_req_d && !rd_done_d) begin
                compare("rd_addr", 32'(rd_addr), 32'(rd_addr_d));
            end
            // A queued request may follow straight after another one.
            if (!en_d && !rd_req_d && !wr_req_d && (rd_req || wr_req)) begin
                fail("request rose after a full cycle with en low");
            end

            if (frame_done) begin
                frames++;
                if (frames > 1) begin
                    compare("reads per frame", reads_in_frame, photon_plot_pkg::RING_DEPTH);
                    compare("pixels of last row", pix_idx, SPAN);
                end
                frame_first = wcount_snap % photon_plot_pkg::RING_DEPTH;
                reads_in_frame = 0;
            end
            wcount_snap = wcount;

            if (wr_done && wr_req && int'(wr_addr) >= RING_LO && int'(wr_addr) < RING_HI) begin
                slot = int'(wr_addr) - RING_LO;
                compare("ring slot", slot, wcount % photon_plot_pkg::RING_DEPTH);
                consume_sample(wr_data);
                shadow[slot] = wr_data;
                wcount++;
            end else if (wr_done && wr_req) begin
                if (pix_idx >= SPAN) begin
                    fail($sformatf("pixel write to 0x%0h outside any row", wr_addr));
                end else begin
                    compare("wr_addr", 32'(wr_addr), row_start + pix_idx);
                    compare("wr_data", 32'(wr_data), (pix_idx <= bar_len) ?
                            int'(photon_plot_pkg::COLOR_BAR) : int'(photon_plot_pkg::COLOR_BG));
                    pix_idx++;
                end
            end

            if (rd_done && rd_req) begin
                slot = int'(rd_addr) - RING_LO;
                if (reads_in_frame >= photon_plot_pkg::RING_DEPTH) fail("read past row 599");
                if (pix_idx != SPAN) fail("ring read before the row was finished");
                compare("rd slot", slot,
                        (frame_first + reads_in_frame) % photon_plot_pkg::RING_DEPTH);
                // SDRAM model and ring shadow agree.
                compare("rd_data", 32'(rd_data),
                        32'(shadow[slot % photon_plot_pkg::RING_DEPTH]));
                bar_len = int'(shadow[slot % photon_plot_pkg::RING_DEPTH]) >>
                          photon_plot_pkg::BAR_SHIFT;
                if (bar_len > SPAN - 1) bar_len = SPAN - 1;  // Clipped bar.
                row_start = (photon_plot_pkg::PLOT_Y_OFFSET + reads_in_frame) *
                            photon_plot_pkg::GRAM_WIDTH + photon_plot_pkg::PLOT_X_OFFSET;
                reads_in_frame++;
                pix_idx = 0;
            end

            if (data_update) strobes.push_back(pulse_count);

            // Oldest pending sample is written or overwritten in time.
            if (strobes.size() == 0) begin
                unwritten = 0;
            end else begin
                unwritten++;
                if (unwritten == SAMPLE_LIMIT) fail("pulse sample never reached the ring");
            end
        end

        en_d      = en;
        rd_req_d  = rd_req;
        wr_req_d  = wr_req;
        rd_done_d = rd_done;
        wr_done_d = wr_done;
        rd_addr_d = rd_addr;
        wr_addr_d = wr_addr;
        wr_data_d = wr_data;
    end

endmodule

`default_nettype wire

// File: dv/photon_plot_tb.sv
`timescale 1ns/100ps
`default_nettype none

module photon_plot_tb;

    localparam int FRAME_TIMEOUT = 5000000;  // Cycles per frame_done wait.
    localparam int RESET_TIMEOUT = 100;
    localparam int FRAMES        = 3;

    logic clk;
    logic rst_n;
    logic en;
    logic data_update;
    photon_plot_pkg::pulse_count_t pulse_count;
    logic rd_req;
    photon_plot_pkg::sdram_addr_t rd_addr;
    photon_plot_pkg::sdram_data_t rd_data;
    logic rd_done;
    logic wr_req;
    photon_plot_pkg::sdram_addr_t wr_addr;
    photon_plot_pkg::sdram_data_t wr_data;
    logic wr_done;
    logic frame_done;
    int   err_count;
    int   check_count;

    // SDRAM model state.
    photon_plot_pkg::sdram_data_t mem [int];  // Sparse word store.
    logic busy;
    logic op_write;
    int   op_addr;
    int   wait_left;

    int   gap_left;      // Cycles to the next strobe.
    int   en_left;       // Cycles to the next en toggle.
    int   frames_seen;
    int   cycles;
    logic timed_out;

    tb_clock_gen tb_clock_gen_i (.clk(clk), .rst_n(rst_n));

    photon_plot_top photon_plot_top_i (
        .clk(clk), .rst_n(rst_n), .en(en),
        .data_update(data_update), .pulse_count(pulse_count),
        .rd_req(rd_req), .rd_addr(rd_addr), .rd_data(rd_data), .rd_done(rd_done),
        .wr_req(wr_req), .wr_addr(wr_addr), .wr_data(wr_data), .wr_done(wr_done),
        .frame_done(frame_done)
    );

    plot_checker plot_checker_i (
        .clk(clk), .rst_n(rst_n), .en(en),
        .data_update(data_update), .pulse_count(pulse_count),
        .rd_req(rd_req), .rd_addr(rd_addr), .rd_data(rd_data), .rd_done(rd_done),
        .wr_req(wr_req), .wr_addr(wr_addr), .wr_data(wr_data), .wr_done(wr_done),
        .frame_done(frame_done), .err_count(err_count), .check_count(check_count)
    );

    ////////////////////////////////////////
    // SDRAM glue model, 1 to 6 cycles.
    ////////////////////////////////////////
    task automatic serve_sdram();
        wr_done = 1'b0;
        rd_done = 1'b0;
        if (busy) begin
            wait_left--;
            if (wait_left == 0) begin
                busy = 1'b0;
                if (op_write) begin
                    mem[op_addr] = wr_data;
                    wr_done = 1'b1;
                end else begin
                    rd_data = mem.exists(op_addr) ? mem[op_addr] : 16'h0000;
                    rd_done = 1'b1;
                end
            end
        end else if (wr_req || rd_req) begin
            busy      = 1'b1;
            op_write  = wr_req;
            op_addr   = wr_req ? int'(wr_addr) : int'(rd_addr);
            wait_left = $urandom_range(1, 6);
        end
    endtask

    // Half small, a quarter just over the clip point, the rest anywhere.
    function automatic photon_plot_pkg::pulse_count_t pick_sample();
        int kind;
        kind = $urandom_range(0, 3);
        if (kind < 2) return photon_plot_pkg::pulse_count_t'($urandom_range(0, 999));
        if (kind == 2) return photon_plot_pkg::pulse_count_t'($urandom_range(941, 1500));
        return photon_plot_pkg::pulse_count_t'($urandom_range(0, 65535));
    endfunction

    task automatic drive_stimulus();
        data_update = 1'b0;
        if (gap_left == 0) begin
            data_update = 1'b1;
            pulse_count = pick_sample();
            gap_left    = $urandom_range(0, 399);
        end else begin
            gap_left--;
        end
        if (en_left == 0) begin
            en      = !en;
            en_left = en ? $urandom_range(200, 3000) : $urandom_range(1, 20);  // Short low spells.
        end else begin
            en_left--;
        end
    endtask

    // One clock, inputs driven 10 ns after the edge.
    task automatic step_cycle();
        logic out_of_reset;  // Reset state seen at the edge.
        @(posedge clk);
        out_of_reset = rst_n;
        #10;
        serve_sdram();
        if (out_of_reset) drive_stimulus();
        if (frame_done) frames_seen++;
    endtask

    initial begin
        en          = 1'b0;
        data_update = 1'b0;
        pulse_count = '0;
        rd_data     = '0;
        rd_done     = 1'b0;
        wr_done     = 1'b0;
        busy        = 1'b0;
        op_write    = 1'b0;
        op_addr     = 0;
        wait_left   = 0;
        frames_seen = 0;
        timed_out   = 1'b0;
        void'($urandom(42188));
        gap_left = $urandom_range(0, 399);
        en_left  = 0;  // Raise en on the first cycle out of reset.

        cycles = 0;
        while (!rst_n && cycles < RESET_TIMEOUT) begin
            step_cycle();
            cycles++;
        end
        if (!rst_n) begin
            timed_out = 1'b1;
            $display("Reset was never released");
        end

        for (int f = 0; f < FRAMES && !timed_out; f++) begin
            cycles = 0;
            while (frames_seen <= f && cycles < FRAME_TIMEOUT) begin
                step_cycle();
                cycles++;
            end
            if (frames_seen <= f) begin
                timed_out = 1'b1;
                $display("Timed out waiting for frame_done pulse %0d", f + 1);
            end
        end

        $display("checks=%0d errors=%0d frames=%0d", check_count, err_count, frames_seen);
        if (!timed_out && err_count == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: photon_plot_top.f
design/photon_plot_pkg.sv
design/sample_logger.sv
design/bar_renderer.sv
design/mem_port_mux.sv
design/photon_plot_top.sv
dv/tb_clock_gen.sv
dv/plot_checker.sv
dv/photon_plot_tb.sv

// File: Makefile
# Verilator build and run for the photon plot testbench.

VERILATOR ?= verilator
TOP       ?= photon_plot_tb
FLIST     ?= photon_plot_top.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing -j 0
PASS_MSG  ?= === PASS ===

SIM_BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(SIM_BIN)

$(SIM_BIN): $(FLIST) $(shell cat $(FLIST))
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FLIST)

run: $(SIM_BIN)
	./$(SIM_BIN) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ]; then exit 1; fi
	@if grep -q -- "$(PASS_MSG)" $(LOG); then \
		echo "Simulation passed"; \
	else \
		echo "Simulation failed, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
